//--- irq_unit.f
logic/irq_pkg.sv
logic/irq_csr_regs.sv
logic/int_controller.sv
logic/irq_trap_ctrl.sv
logic/irq_unit_top.sv
bench/irq_unit_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the irq_unit simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=irq_unit_sim

verilator --binary --timing --assert -f irq_unit.f --top-module irq_unit_tb \
  -Mdir "$OBJ" -o "$BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  exit 1
fi
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

//--- bench/irq_unit_tb.sv
`timescale 1ns/1ps

module irq_unit_tb;

  localparam logic [31:0] MTVEC_INIT = 32'h0000_1001;
  // Software, timer, external and the fast lines
  localparam logic [31:0] IMPL_LINES = 32'hFFFF_0000 | (32'd1 << 11) | (32'd1 << 7) |
                                       (32'd1 << 3);

  // Worst case of one bus access including back-pressure
  localparam int BUS_CYCLES  = 8;
  localparam int TEST_CYCLES = 84 * BUS_CYCLES + 36 * BUS_CYCLES + 20 * (BUS_CYCLES + 6) +
                               30 * (3 * BUS_CYCLES + 30) + 20 * (BUS_CYCLES + 6) +
                               10 * (2 * BUS_CYCLES + 40);
  localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

  logic                clk;
  logic                arst_n;
  logic                awvalid;
  logic                awready;
  logic [3:0]          awaddr;
  logic                wvalid;
  logic                wready;
  logic [31:0]         wdata;
  logic [3:0]          wstrb;
  logic                bvalid;
  logic                bready;
  irq_pkg::axil_resp_e bresp;
  logic                arvalid;
  logic                arready;
  logic [3:0]          araddr;
  logic                rvalid;
  logic                rready;
  logic [31:0]         rdata;
  irq_pkg::axil_resp_e rresp;
  logic [31:0]         irq;
  logic                irq_ack;
  logic                irq_req;
  logic                irq_wu;
  irq_pkg::irq_trap_t  trap;

  // Reference copy of the CSRs
  logic [31:0]         m_mie;
  logic                m_gie;
  logic [31:0]         m_mtvec;
  logic [31:0]         rng_state;
  int                  cycles = 0;

  irq_unit_top #(
    .MTVEC_RESET      ( MTVEC_INIT )
  ) irq_unit_top_i (
    .clk_i            ( clk        ),
    .arst_n_i         ( arst_n     ),
    .s_axil_awvalid_i ( awvalid    ),
    .s_axil_awready_o ( awready    ),
    .s_axil_awaddr_i  ( awaddr     ),
    .s_axil_wvalid_i  ( wvalid     ),
    .s_axil_wready_o  ( wready     ),
    .s_axil_wdata_i   ( wdata      ),
    .s_axil_wstrb_i   ( wstrb      ),
    .s_axil_bvalid_o  ( bvalid     ),
    .s_axil_bready_i  ( bready     ),
    .s_axil_bresp_o   ( bresp      ),
    .s_axil_arvalid_i ( arvalid    ),
    .s_axil_arready_o ( arready    ),
    .s_axil_araddr_i  ( araddr     ),
    .s_axil_rvalid_o  ( rvalid     ),
    .s_axil_rready_i  ( rready     ),
    .s_axil_rdata_o   ( rdata      ),
    .s_axil_rresp_o   ( rresp      ),
    .irq_i            ( irq        ),
    .irq_ack_i        ( irq_ack    ),
    .irq_req_o        ( irq_req    ),
    .irq_trap_o       ( trap       ),
    .irq_wu_o         ( irq_wu     )
  );

  // 8 ns period
  initial clk = 1'b0;
  always #4 clk = ~clk;

  //////////////////////////////
  // Random numbers
  //////////////////////////////

  function automatic logic [31:0] rand_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Upper bits only since the low ones cycle too fast
  function automatic int rand_range(int n);
    logic [31:0] r;
    r = rand_next();
    return int'(r[30:16]) % n;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = rand_next();
    lo = rand_next();
    return {hi[31:16], lo[31:16]};
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [31:0] lane_merge(logic [31:0] old_word, logic [31:0] new_word,
                                             logic [3:0] strb);
    logic [31:0] lanes;
    lanes = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~lanes) | (new_word & lanes);
  endfunction

  // mie, mstatus, mtvec and mip sit on word offsets
  function automatic logic offset_mapped(logic [3:0] offset);
    return offset[1:0] == 2'b00;
  endfunction

  function automatic void model_write(logic [3:0] offset, logic [31:0] data, logic [3:0] strb);
    logic [31:0] merged;
    case (offset)
      4'h0: m_mie = lane_merge(m_mie, data, strb) & IMPL_LINES;
      4'h4: begin
        merged = lane_merge({28'd0, m_gie, 3'd0}, data, strb);
        m_gie  = merged[3];
      end
      4'h8: begin
        merged = lane_merge(m_mtvec, data, strb);
        // Modes 2 and 3 leave the mode alone
        if (merged[1:0] < 2'd2)
          m_mtvec = merged;
        else
          m_mtvec = {merged[31:2], m_mtvec[1:0]};
      end
      default: ;
    endcase
  endfunction

  // mip only valid with irq steady
  function automatic logic [31:0] model_read(logic [3:0] offset);
    case (offset)
      4'h0:    return m_mie;
      4'h4:    return {28'd0, m_gie, 3'd0};
      4'h8:    return m_mtvec;
      4'hC:    return irq & IMPL_LINES;
      default: return 32'd0;
    endcase
  endfunction

  // Valid bit on top, id below
  function automatic logic [5:0] model_select(logic [31:0] pend);
    for (int i = 31; i >= 16; i--) begin
      if (pend[i]) return {1'b1, 5'(i)};
    end
    if (pend[11]) return {1'b1, 5'd11};
    if (pend[3]) return {1'b1, 5'd3};
    if (pend[7]) return {1'b1, 5'd7};
    return 6'd0;
  endfunction

  function automatic logic [31:0] model_target(logic [4:0] id);
    logic [31:0] base_addr;
    base_addr = {m_mtvec[31:2], 2'b00};
    if (m_mtvec[1:0] == 2'd1) return base_addr + 32'(id) * 32'd4;
    return base_addr;
  endfunction

  task automatic check_val(string test, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error: %s expected 0x%08h actual 0x%08h", test, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Mismatch in %s", test);
    end
  endtask

  //////////////////////////////
  // Bus and core tasks
  //////////////////////////////

  task automatic bus_write(logic [3:0] offset, logic [31:0] data, logic [3:0] strb);
    int          hold;
    logic [31:0] exp_resp;
    exp_resp = offset_mapped(offset) ? 32'd0 : 32'd2;
    @(posedge clk);
    #1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    awaddr  = offset;
    wdata   = data;
    wstrb   = strb;
    @(negedge clk);
    while (!awready) @(negedge clk);
    // Address and data ready in the same cycle
    check_val("wready_accept", 32'd1, 32'(wready));
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    model_write(offset, data, strb);
    // Response one cycle after acceptance, then held
    @(negedge clk);
    check_val("bvalid_next", 32'd1, 32'(bvalid));
    hold = rand_range(4);
    repeat (hold) begin
      @(negedge clk);
      check_val("bvalid_held", 32'd1, 32'(bvalid));
      check_val("bresp_held", exp_resp, 32'(bresp));
    end
    @(posedge clk);
    #1;
    bready = 1'b1;
    @(negedge clk);
    check_val("bresp", exp_resp, 32'(bresp));
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic bus_read(logic [3:0] offset, output logic [31:0] data);
    int          hold;
    logic [31:0] first_data;
    logic [31:0] exp_resp;
    exp_resp = offset_mapped(offset) ? 32'd0 : 32'd2;
    @(posedge clk);
    #1;
    arvalid = 1'b1;
    araddr  = offset;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    @(negedge clk);
    check_val("rvalid_next", 32'd1, 32'(rvalid));
    first_data = rdata;
    hold = rand_range(4);
    repeat (hold) begin
      @(negedge clk);
      check_val("rvalid_held", 32'd1, 32'(rvalid));
      check_val("rdata_held", first_data, rdata);
    end
    @(posedge clk);
    #1;
    rready = 1'b1;
    @(negedge clk);
    check_val("rdata_final", first_data, rdata);
    check_val("rresp", exp_resp, 32'(rresp));
    @(posedge clk);
    #1;
    rready = 1'b0;
    data = first_data;
  endtask

  // Transfer then one low cycle
  task automatic ack_request();
    @(posedge clk);
    #1;
    irq_ack = 1'b1;
    @(negedge clk);
    check_val("ack_req_high", 32'd1, 32'(irq_req));
    @(posedge clk);
    #1;
    irq_ack = 1'b0;
    @(negedge clk);
    check_val("ack_gap", 32'd0, 32'(irq_req));
  endtask

  // Lines low then clear any open request
  task automatic drain_requests();
    @(posedge clk);
    #1;
    irq = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    while (irq_req) begin
      ack_request();
    end
  endtask

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("Timeout: run still busy after %0d cycles", cycles);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Simulation timeout");
    end
  end

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial begin
    logic [31:0]        data;
    logic [31:0]        lines;
    logic [3:0]         offset;
    logic [5:0]         pick;
    irq_pkg::irq_trap_t held;
    int                 hold;

    rng_state = 32'd78;
    arst_n    = 1'b0;
    awvalid   = 1'b0;
    awaddr    = '0;
    wvalid    = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    bready    = 1'b0;
    arvalid   = 1'b0;
    araddr    = '0;
    rready    = 1'b0;
    irq       = '0;
    irq_ack   = 1'b0;
    m_mie     = '0;
    m_gie     = 1'b0;
    m_mtvec   = MTVEC_INIT;
    repeat (16) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // Reset values
    @(negedge clk);
    check_val("reset_req", 32'd0, 32'(irq_req));
    check_val("reset_wu", 32'd0, 32'(irq_wu));
    check_val("reset_bvalid", 32'd0, 32'(bvalid));
    check_val("reset_rvalid", 32'd0, 32'(rvalid));
    check_val("reset_awready", 32'd0, 32'(awready));
    check_val("reset_wready", 32'd0, 32'(wready));
    check_val("reset_arready", 32'd0, 32'(arready));
    for (int k = 0; k < 4; k++) begin
      bus_read(4'(k * 4), data);
      check_val("reset_csr", model_read(4'(k * 4)), data);
    end

    // CSR access with random strobes
    for (int n = 0; n < 40; n++) begin
      offset = 4'(rand_range(4) * 4);
      bus_write(offset, rand_word(), 4'(rand_range(16)));
      bus_read(offset, data);
      check_val("csr_readback", model_read(offset), data);
    end

    // Unmapped offsets leave the CSRs alone
    for (int n = 0; n < 16; n++) begin
      offset = 4'(rand_range(16));
      if (offset_mapped(offset)) offset = offset | 4'h1;
      bus_write(offset, rand_word(), 4'hF);
      bus_read(offset, data);
      check_val("unmapped_read", 32'd0, data);
    end
    for (int k = 0; k < 4; k++) begin
      bus_read(4'(k * 4), data);
      check_val("unmapped_keep", model_read(4'(k * 4)), data);
    end

    // Pending readback
    for (int n = 0; n < 20; n++) begin
      lines = rand_word();
      @(posedge clk);
      #1;
      irq = lines;
      repeat (4) @(posedge clk);
      bus_read(4'hC, data);
      check_val("mip_read", lines & IMPL_LINES, data);
    end

    // Selection and target with sparse lines so low ids win too
    bus_write(4'h4, 32'h0000_0008, 4'hF);
    for (int n = 0; n < 30; n++) begin
      drain_requests();
      bus_write(4'h0, rand_word() & rand_word(), 4'hF);
      data = rand_word();
      bus_write(4'h8, {data[31:2], 1'b0, data[0]}, 4'hF);
      lines = rand_word() & rand_word();
      @(posedge clk);
      #1;
      irq = lines;
      // Two sync flops, mip, then the raise
      repeat (4) @(posedge clk);
      @(negedge clk);
      pick = model_select(lines & IMPL_LINES & m_mie);
      check_val("sel_req", 32'(pick[5]), 32'(irq_req));
      check_val("sel_wu", 32'(|(lines & IMPL_LINES & m_mie)), 32'(irq_wu));
      if (pick[5]) begin
        check_val("sel_id", 32'(pick[4:0]), 32'(trap.id));
        check_val("sel_target", model_target(pick[4:0]), trap.target);
      end
    end
    drain_requests();

    // Global enable clear with wake-up still live
    bus_write(4'h4, 32'h0000_0000, 4'h1);
    for (int n = 0; n < 20; n++) begin
      bus_write(4'h0, rand_word() & rand_word(), 4'hF);
      lines = rand_word() & rand_word();
      @(posedge clk);
      #1;
      irq = lines;
      repeat (5) begin
        @(negedge clk);
        check_val("gie_no_req", 32'd0, 32'(irq_req));
      end
      check_val("gie_wu", 32'(|(lines & IMPL_LINES & m_mie)), 32'(irq_wu));
    end
    drain_requests();

    // Request hold under a slow acknowledge
    bus_write(4'h4, 32'hFFFF_FFFF, 4'hF);
    bus_write(4'h0, 32'hFFFF_FFFF, 4'hF);
    data = rand_word();
    bus_write(4'h8, {data[31:2], 2'b01}, 4'hF);
    for (int n = 0; n < 10; n++) begin
      @(posedge clk);
      #1;
      irq = rand_word() | 32'h0001_0000;
      repeat (4) @(posedge clk);
      @(negedge clk);
      check_val("hold_raise", 32'd1, 32'(irq_req));
      held = trap;
      hold = 1 + rand_range(8);
      // Lines move while the payload holds
      repeat (hold + 4) begin
        @(posedge clk);
        #1;
        if (hold > 0) irq = rand_word();
        else irq = lines;
        hold = hold - 1;
        if (hold == 0) lines = rand_word() | 32'h0000_0080;
        @(negedge clk);
        check_val("hold_req", 32'd1, 32'(irq_req));
        check_val("hold_id", 32'(held.id), 32'(trap.id));
        check_val("hold_target", held.target, trap.target);
      end
      ack_request();
      // Still pending so up again after the gap
      @(negedge clk);
      pick = model_select(lines & IMPL_LINES & m_mie);
      check_val("hold_reraise", 32'd1, 32'(irq_req));
      check_val("hold_reraise_id", 32'(pick[4:0]), 32'(trap.id));
      check_val("hold_reraise_target", model_target(pick[4:0]), trap.target);
      drain_requests();
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- logic/irq_unit_top.sv
`timescale 1ns/1ps

module irq_unit_top #(
  parameter irq_pkg::mtvec_t MTVEC_RESET = 32'h0000_1001
) (
  input  logic                            clk_i,
  input  logic                            arst_n_i,

  // AXI4-Lite CSR slave
  input  logic                            s_axil_awvalid_i,
  output logic                            s_axil_awready_o,
  input  logic [irq_pkg::AXIL_ADDR_W-1:0] s_axil_awaddr_i,
  input  logic                            s_axil_wvalid_i,
  output logic                            s_axil_wready_o,
  input  logic [31:0]                     s_axil_wdata_i,
  input  logic [3:0]                      s_axil_wstrb_i,
  output logic                            s_axil_bvalid_o,
  input  logic                            s_axil_bready_i,
  output irq_pkg::axil_resp_e             s_axil_bresp_o,
  input  logic                            s_axil_arvalid_i,
  output logic                            s_axil_arready_o,
  input  logic [irq_pkg::AXIL_ADDR_W-1:0] s_axil_araddr_i,
  output logic                            s_axil_rvalid_o,
  input  logic                            s_axil_rready_i,
  output logic [31:0]                     s_axil_rdata_o,
  output irq_pkg::axil_resp_e             s_axil_rresp_o,

  // Interrupt lines and core handshake
  input  irq_pkg::irq_vec_t               irq_i,
  input  logic                            irq_ack_i,
  output logic                            irq_req_o,
  output irq_pkg::irq_trap_t              irq_trap_o,
  output logic                            irq_wu_o
);

  irq_pkg::irq_cfg_t cfg;
  irq_pkg::irq_vec_t mip;
  irq_pkg::irq_sel_t sel;

  ////////////////////////////////
  // CSR block
  ////////////////////////////////

  irq_csr_regs #(
    .MTVEC_RESET      ( MTVEC_RESET      )
  ) irq_csr_regs_i (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .s_axil_awvalid_i ( s_axil_awvalid_i ),
    .s_axil_awready_o ( s_axil_awready_o ),
    .s_axil_awaddr_i  ( s_axil_awaddr_i  ),
    .s_axil_wvalid_i  ( s_axil_wvalid_i  ),
    .s_axil_wready_o  ( s_axil_wready_o  ),
    .s_axil_wdata_i   ( s_axil_wdata_i   ),
    .s_axil_wstrb_i   ( s_axil_wstrb_i   ),
    .s_axil_bvalid_o  ( s_axil_bvalid_o  ),
    .s_axil_bready_i  ( s_axil_bready_i  ),
    .s_axil_bresp_o   ( s_axil_bresp_o   ),
    .s_axil_arvalid_i ( s_axil_arvalid_i ),
    .s_axil_arready_o ( s_axil_arready_o ),
    .s_axil_araddr_i  ( s_axil_araddr_i  ),
    .s_axil_rvalid_o  ( s_axil_rvalid_o  ),
    .s_axil_rready_i  ( s_axil_rready_i  ),
    .s_axil_rdata_o   ( s_axil_rdata_o   ),
    .s_axil_rresp_o   ( s_axil_rresp_o   ),
    .mip_i            ( mip              ),
    .cfg_o            ( cfg              )
  );

  // Pending, masking and priority
  int_controller int_controller_i (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .irq_i            ( irq_i            ),
    .cfg_i            ( cfg              ),
    .mip_o            ( mip              ),
    .sel_o            ( sel              ),
    .irq_wu_o         ( irq_wu_o         )
  );

  // Request towards the core
  irq_trap_ctrl irq_trap_ctrl_i (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .sel_i            ( sel              ),
    .cfg_i            ( cfg              ),
    .irq_ack_i        ( irq_ack_i        ),
    .irq_req_o        ( irq_req_o        ),
    .irq_trap_o       ( irq_trap_o       )
  );

endmodule

//--- logic/irq_trap_ctrl.sv
`timescale 1ns/1ps

module irq_trap_ctrl (
  input  logic               clk_i,
  input  logic               arst_n_i,

  // Winner and trap vector configuration
  input  irq_pkg::irq_sel_t  sel_i,
  input  irq_pkg::irq_cfg_t  cfg_i,

  // Request handshake with the core
  input  logic               irq_ack_i,
  output logic               irq_req_o,
  output irq_pkg::irq_trap_t irq_trap_o
);

  typedef enum logic [1:0] {
    TRAP_IDLE,
    TRAP_REQ,
    TRAP_COOL
  } trap_state_e;

  trap_state_e        state_q, state_d;
  logic               load;
  logic [31:0]        vec_offset;
  logic [31:0]        target_d;
  irq_pkg::irq_trap_t trap_q;

  ////////////////////////////////
  // Trap target
  ////////////////////////////////

  // Four bytes per vector slot
  assign vec_offset = {25'd0, sel_i.id, 2'b00};
  assign target_d   = {cfg_i.mtvec.base, 2'b00} +
                      ((cfg_i.mtvec.mode == irq_pkg::MTVEC_VECTORED) ? vec_offset : 32'd0);

  ////////////////////////////////
  // Request FSM
  ////////////////////////////////

  // Cooldown may raise again directly, so low for exactly one cycle
  assign load = (state_q != TRAP_REQ) && sel_i.valid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      TRAP_IDLE: if (sel_i.valid) state_d = TRAP_REQ;
      TRAP_REQ:  if (irq_ack_i) state_d = TRAP_COOL;
      TRAP_COOL: state_d = sel_i.valid ? TRAP_REQ : TRAP_IDLE;
      default:   state_d = TRAP_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) state_q <= TRAP_IDLE;
    else           state_q <= state_d;
  end

  // Payload frozen while requesting
  always_ff @(posedge clk_i) begin
    if (load) begin
      trap_q.id     <= sel_i.id;
      trap_q.target <= target_d;
    end
  end

  assign irq_req_o  = (state_q == TRAP_REQ);
  assign irq_trap_o = trap_q;

  a_req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    irq_req_o && !irq_ack_i |=> irq_req_o && $stable(irq_trap_o));

endmodule

//--- logic/int_controller.sv
`timescale 1ns/1ps

module int_controller (
  input  logic              clk_i,
  input  logic              arst_n_i,

  // Asynchronous interrupt lines
  input  irq_pkg::irq_vec_t irq_i,

  // From the CSR block
  input  irq_pkg::irq_cfg_t cfg_i,

  // Pending lines, winner and wake-up
  output irq_pkg::irq_vec_t mip_o,
  output irq_pkg::irq_sel_t sel_o,
  output logic              irq_wu_o
);

  // Two-flop synchronizer
  irq_pkg::irq_vec_t sync1_q, sync2_q;
  irq_pkg::irq_vec_t mip_q;

  // Pending and enabled
  irq_pkg::irq_vec_t pend;
  irq_pkg::irq_id_t  win_id;

  ////////////////////////////////
  // Synchronizer and mip
  ////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      mip_q   <= '0;
    end else begin
      sync1_q <= irq_i;
      sync2_q <= sync1_q;
      // Lines that do not exist never pend
      mip_q   <= sync2_q & irq_pkg::IRQ_IMPL_MASK;
    end
  end

  assign pend = mip_q & cfg_i.mie;

  ////////////////////////////////
  // Priority selection
  ////////////////////////////////

  // Later hits override earlier ones
  // Order is 31..16, then 11, 3, 7
  always_comb begin
    win_id = '0;
    if (pend[7])  win_id = 5'd7;
    if (pend[3])  win_id = 5'd3;
    if (pend[11]) win_id = 5'd11;
    for (int i = 16; i < 32; i++) begin
      if (pend[i]) begin
        win_id = irq_pkg::irq_id_t'(i);
      end
    end
  end

  // Wake-up ignores the global enable
  assign irq_wu_o = |pend;

  assign sel_o.valid = irq_wu_o && cfg_i.mie_global;
  assign sel_o.id    = win_id;
  assign mip_o       = mip_q;

  a_sel_pending: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    sel_o.valid |-> (mip_o[sel_o.id] && cfg_i.mie[sel_o.id]));

endmodule

//--- logic/irq_csr_regs.sv
`timescale 1ns/1ps

module irq_csr_regs #(
  parameter irq_pkg::mtvec_t MTVEC_RESET = 32'h0000_1001
) (
  input  logic                            clk_i,
  input  logic                            arst_n_i,

  // AXI4-Lite write address and data
  input  logic                            s_axil_awvalid_i,
  output logic                            s_axil_awready_o,
  input  logic [irq_pkg::AXIL_ADDR_W-1:0] s_axil_awaddr_i,
  input  logic                            s_axil_wvalid_i,
  output logic                            s_axil_wready_o,
  input  logic [31:0]                     s_axil_wdata_i,
  input  logic [3:0]                      s_axil_wstrb_i,

  // AXI4-Lite write response
  output logic                            s_axil_bvalid_o,
  input  logic                            s_axil_bready_i,
  output irq_pkg::axil_resp_e             s_axil_bresp_o,

  // AXI4-Lite read
  input  logic                            s_axil_arvalid_i,
  output logic                            s_axil_arready_o,
  input  logic [irq_pkg::AXIL_ADDR_W-1:0] s_axil_araddr_i,
  output logic                            s_axil_rvalid_o,
  input  logic                            s_axil_rready_i,
  output logic [31:0]                     s_axil_rdata_o,
  output irq_pkg::axil_resp_e             s_axil_rresp_o,

  // Pending lines and configuration
  input  irq_pkg::irq_vec_t               mip_i,
  output irq_pkg::irq_cfg_t               cfg_o
);

  // CSR storage
  irq_pkg::irq_vec_t   mie_q, mie_d;
  logic                mie_global_q, mie_global_d;
  irq_pkg::mtvec_t     mtvec_q, mtvec_d;
  logic [31:0]         mstatus_word;

  // Bus state
  logic                wr_accept, rd_accept;
  logic                bvalid_q, rvalid_q;
  logic [31:0]         wr_merged;
  logic [31:0]         rd_data, rdata_q;
  irq_pkg::axil_resp_e wr_resp, rd_resp, bresp_q, rresp_q;

  // Byte lanes under wstrb
  function automatic logic [31:0] merge_bytes(logic [31:0] old_word, logic [31:0] new_word,
                                              logic [3:0] strb);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return res;
  endfunction

  assign mstatus_word = 32'(mie_global_q) << irq_pkg::MSTATUS_MIE_BIT;

  ////////////////////////////////
  // Write path
  ////////////////////////////////

  // Address and data taken together, one response outstanding
  assign wr_accept        = s_axil_awvalid_i && s_axil_wvalid_i && !bvalid_q;
  assign s_axil_awready_o = wr_accept;
  assign s_axil_wready_o  = wr_accept;

  always_comb begin
    mie_d        = mie_q;
    mie_global_d = mie_global_q;
    mtvec_d      = mtvec_q;
    wr_merged    = '0;
    wr_resp      = irq_pkg::OKAY;
    case (s_axil_awaddr_i)
      irq_pkg::CSR_MIE: begin
        wr_merged = merge_bytes(mie_q, s_axil_wdata_i, s_axil_wstrb_i);
        if (wr_accept) mie_d = wr_merged & irq_pkg::IRQ_IMPL_MASK;
      end
      irq_pkg::CSR_MSTATUS: begin
        wr_merged = merge_bytes(mstatus_word, s_axil_wdata_i, s_axil_wstrb_i);
        if (wr_accept) mie_global_d = wr_merged[irq_pkg::MSTATUS_MIE_BIT];
      end
      irq_pkg::CSR_MTVEC: begin
        wr_merged = merge_bytes(mtvec_q, s_axil_wdata_i, s_axil_wstrb_i);
        if (wr_accept) begin
          mtvec_d.base = wr_merged[31:2];
          // Reserved modes keep the old mode
          if (wr_merged[1:0] == irq_pkg::MTVEC_DIRECT ||
              wr_merged[1:0] == irq_pkg::MTVEC_VECTORED) begin
            mtvec_d.mode = wr_merged[1:0];
          end
        end
      end
      // Read-only, write dropped
      irq_pkg::CSR_MIP: wr_resp = irq_pkg::OKAY;
      default:          wr_resp = irq_pkg::SLVERR;
    endcase
  end

  ////////////////////////////////
  // Read path
  ////////////////////////////////

  assign rd_accept        = s_axil_arvalid_i && !rvalid_q;
  assign s_axil_arready_o = rd_accept;

  always_comb begin
    rd_resp = irq_pkg::OKAY;
    case (s_axil_araddr_i)
      irq_pkg::CSR_MIE:     rd_data = mie_q;
      irq_pkg::CSR_MSTATUS: rd_data = mstatus_word;
      irq_pkg::CSR_MTVEC:   rd_data = mtvec_q;
      irq_pkg::CSR_MIP:     rd_data = mip_i;
      default: begin
        rd_data = '0;
        rd_resp = irq_pkg::SLVERR;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mie_q        <= '0;
      mie_global_q <= 1'b0;
      mtvec_q      <= MTVEC_RESET;
      bvalid_q     <= 1'b0;
      rvalid_q     <= 1'b0;
    end else begin
      mie_q        <= mie_d;
      mie_global_q <= mie_global_d;
      mtvec_q      <= mtvec_d;
      // Responses held until their ready
      if (wr_accept) bvalid_q <= 1'b1;
      else if (s_axil_bready_i) bvalid_q <= 1'b0;
      if (rd_accept) rvalid_q <= 1'b1;
      else if (s_axil_rready_i) rvalid_q <= 1'b0;
    end
  end

  // Response payload
  always_ff @(posedge clk_i) begin
    if (wr_accept) bresp_q <= wr_resp;
    if (rd_accept) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
  end

  assign s_axil_bvalid_o = bvalid_q;
  assign s_axil_bresp_o  = bresp_q;
  assign s_axil_rvalid_o = rvalid_q;
  assign s_axil_rdata_o  = rdata_q;
  assign s_axil_rresp_o  = rresp_q;

  assign cfg_o.mie        = mie_q;
  assign cfg_o.mie_global = mie_global_q;
  assign cfg_o.mtvec      = mtvec_q;

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o);

  a_rdata_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    s_axil_rvalid_o && !s_axil_rready_i |=> $stable(s_axil_rdata_o));

endmodule

//--- logic/irq_pkg.sv
package irq_pkg;

  ////////////////////////////////
  // Interrupt vectors
  ////////////////////////////////

  // One bit per interrupt line
  typedef logic [31:0] irq_vec_t;
  typedef logic [4:0]  irq_id_t;

  // Software 3, timer 7, external 11, fast 16 to 31
  localparam irq_vec_t IRQ_IMPL_MASK = 32'hFFFF_0888;

  ////////////////////////////////
  // CSR map on the AXI4-Lite slave
  ////////////////////////////////

  localparam int AXIL_ADDR_W = 4;

  typedef enum logic [3:0] {
    CSR_MIE     = 4'h0,
    CSR_MSTATUS = 4'h4,
    CSR_MTVEC   = 4'h8,
    CSR_MIP     = 4'hC
  } csr_offset_e;

  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2
  } axil_resp_e;

  // Global enable position in mstatus
  localparam int MSTATUS_MIE_BIT = 3;

  // Base is a word address
  typedef struct packed {
    logic [29:0] base;
    logic [1:0]  mode;
  } mtvec_t;

  localparam logic [1:0] MTVEC_DIRECT   = 2'd0;
  localparam logic [1:0] MTVEC_VECTORED = 2'd1;

  ////////////////////////////////
  // Internal block interfaces
  ////////////////////////////////

  // CSR block to both controllers
  typedef struct packed {
    irq_vec_t mie;
    logic     mie_global;
    mtvec_t   mtvec;
  } irq_cfg_t;

  // Winning interrupt
  typedef struct packed {
    logic    valid;
    irq_id_t id;
  } irq_sel_t;

  // Trap request payload
  typedef struct packed {
    irq_id_t     id;
    logic [31:0] target;
  } irq_trap_t;

endpackage
